//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_trs_cmd
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/cmd_exec.sv
`default_nettype none

module cmd_exec (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           action,
  input  wire trs_pkg::cmd_t  cmd,
  input  wire trs_pkg::byte_t p0,
  input  wire trs_pkg::byte_t p1,
  input  wire trs_pkg::byte_t p2,
  output trs_pkg::byte_t      reply_byte,
  output logic                reply_valid,
  output trs_pkg::color_t     screen_color
);

  trs_pkg::byte_t    mem [1 << trs_pkg::MEM_ADDR_W];  // local byte memory
  trs_pkg::mem_addr_t addr;
  trs_pkg::byte_t    rd_data;   // registered read port
  logic              peek_q;    // read in flight
  logic              do_poke;
  logic              do_peek;
  logic              do_query;

  // low bits of {hi, lo}, upper bits alias
  assign addr = trs_pkg::mem_addr_t'({p1, p0});

  assign do_poke  = action && (cmd == trs_pkg::CMD_BRAM_POKE);
  assign do_peek  = action && (cmd == trs_pkg::CMD_BRAM_PEEK);
  assign do_query = action && (cmd == trs_pkg::CMD_GET_COOKIE ||
                               cmd == trs_pkg::CMD_GET_VERSION);

  // memory port
  always_ff @(posedge clk) begin
    if (do_poke)
      mem[addr] <= p2;
    if (do_peek)
      rd_data <= mem[addr];
  end

  // peek pipeline, one deep
  always_ff @(posedge clk) begin
    if (!rst_n)
      peek_q <= 1'b0;
    else
      peek_q <= do_peek;
  end

  // reply strobe and data
  always_ff @(posedge clk) begin
    if (!rst_n)
      reply_valid <= 1'b0;
    else
      reply_valid <= peek_q || do_query;
  end

  always_ff @(posedge clk) begin
    if (peek_q) begin
      reply_byte <= rd_data;  // peek data wins over a query
    end else if (do_query) begin
      if (cmd == trs_pkg::CMD_GET_COOKIE)
        reply_byte <= trs_pkg::COOKIE;
      else
        reply_byte <= {trs_pkg::VERSION_MAJOR, trs_pkg::VERSION_MINOR};
    end
  end

  // screen colour register
  always_ff @(posedge clk) begin
    if (!rst_n)
      screen_color <= trs_pkg::COLOR_RESET;
    else if (action && cmd == trs_pkg::CMD_SET_SCREEN_COLOR)
      screen_color <= {p0, p1, p2};  // red on top
  end

endmodule

`default_nettype wire

//--- logic/cmd_parser.sv
`default_nettype none

module cmd_parser (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire trs_pkg::byte_t rx_byte,
  input  wire logic           rx_valid,
  input  wire logic           msg_start,
  output logic                action,
  output trs_pkg::cmd_t       cmd,
  output trs_pkg::byte_t      p0,
  output trs_pkg::byte_t      p1,
  output trs_pkg::byte_t      p2
);

  trs_pkg::parse_state_t state;
  trs_pkg::param_cnt_t   remaining;  // params still to read
  trs_pkg::param_cnt_t   slot;       // next param slot
  trs_pkg::byte_t        params [trs_pkg::MAX_PARAMS];
  logic                  known;
  trs_pkg::param_cnt_t   n_params;

  // decode of the incoming byte as a command
  assign known    = trs_pkg::cmd_is_known(rx_byte);
  assign n_params = trs_pkg::cmd_param_cnt(rx_byte);

  // control path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= trs_pkg::PARSE_IDLE;
      action    <= 1'b0;
      remaining <= '0;
      slot      <= '0;
    end else begin
      action <= 1'b0;  // single-cycle strobe
      if (msg_start) begin
        state <= trs_pkg::PARSE_IDLE;  // drop partial command
      end else if (rx_valid) begin
        case (state)
          trs_pkg::PARSE_IDLE: begin
            slot      <= '0;
            remaining <= n_params;
            if (known) begin
              if (n_params == 2'd0)
                action <= 1'b1;  // query, fire now
              else
                state <= trs_pkg::PARSE_PARAMS;
            end
            // unknown code, stay idle
          end
          trs_pkg::PARSE_PARAMS: begin
            slot <= slot + 2'd1;
            if (remaining == 2'd1) begin
              action <= 1'b1;  // last param in
              state  <= trs_pkg::PARSE_IDLE;
            end else begin
              remaining <= remaining - 2'd1;
            end
          end
          default: state <= trs_pkg::PARSE_IDLE;
        endcase
      end
    end
  end

  // command and parameter capture
  always_ff @(posedge clk) begin
    if (rx_valid && !msg_start) begin
      if (state == trs_pkg::PARSE_IDLE && known)
        cmd <= trs_pkg::cmd_t'(rx_byte);
      if (state == trs_pkg::PARSE_PARAMS)
        params[slot] <= rx_byte;  // p0, p1, p2 in order
    end
  end

  assign p0 = params[0];  // addr lo / red
  assign p1 = params[1];  // addr hi / green
  assign p2 = params[2];  // data / blue

endmodule

`default_nettype wire

//--- logic/spi_link.sv
`default_nettype none

module spi_link (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           sck,
  input  wire logic           mosi,
  input  wire logic           cs_n,
  output logic                miso,
  output trs_pkg::byte_t      rx_byte,
  output logic                rx_valid,
  output logic                msg_start,
  input  wire trs_pkg::byte_t reply_byte,
  input  wire logic           reply_valid,
  output logic                reply_pending
);

  logic [2:0]     sck_q;     // 2-flop sync + edge flop
  logic [2:0]     cs_q;
  logic [1:0]     mosi_q;
  logic           sck_rise;
  logic           sck_fall;
  logic           cs_fall;
  logic           cs_rise;
  logic           cs_active;
  logic [2:0]     bit_cnt;   // bits of current byte
  trs_pkg::byte_t rx_sr;     // mosi shift, msb first
  logic           byte_done; // 8th bit in, not suppressed
  trs_pkg::byte_t tx_sr;     // reply shift, msb on miso
  logic [2:0]     tx_rises;  // sck rises since load

  // pin synchronisers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_q  <= '0;
      cs_q   <= '1;  // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_fall   = (cs_q[2:1] == 2'b10);
  assign cs_rise   = (cs_q[2:1] == 2'b01);
  assign cs_active = ~cs_q[1];

  // receive side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      // byte clocked under a reply is dropped here
      byte_done <= cs_active && sck_rise && (bit_cnt == 3'd7) && !reply_pending;
      if (!cs_active)
        bit_cnt <= '0;  // resync on every message
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_sr <= {rx_sr[6:0], mosi_q[1]};
    if (byte_done)
      rx_byte <= rx_sr;  // stable alongside rx_valid
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_valid  <= 1'b0;
      msg_start <= 1'b0;
    end else begin
      rx_valid  <= byte_done;
      msg_start <= cs_fall;  // parser back to idle
    end
  end

  // transmit side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_sr         <= '0;
      tx_rises      <= '0;
      reply_pending <= 1'b0;
    end else if (reply_valid) begin
      tx_sr         <= reply_byte;  // bit 7 out at once
      tx_rises      <= '0;
      reply_pending <= 1'b1;
    end else if (cs_rise) begin
      reply_pending <= 1'b0;  // host gave up on the reply
    end else if (reply_pending) begin
      if (sck_rise) begin
        tx_rises <= tx_rises + 3'd1;
        if (tx_rises == 3'd7)
          reply_pending <= 1'b0;  // 8th bit sampled by host
      end
      // first fall after load belongs to no bit yet
      if (sck_fall && tx_rises != 3'd0)
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = ~cs_n & tx_sr[7];  // low while deselected

endmodule

`default_nettype wire

//--- logic/trs_cmd_top.sv
`default_nettype none

module trs_cmd_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            sck,
  input  wire logic            mosi,
  input  wire logic            cs_n,
  output wire logic            miso,
  output wire trs_pkg::color_t screen_color
);

  wire trs_pkg::byte_t rx_byte;
  wire logic           rx_valid;
  wire logic           msg_start;
  wire logic           action;
  wire trs_pkg::cmd_t  cmd;
  wire trs_pkg::byte_t p0;
  wire trs_pkg::byte_t p1;
  wire trs_pkg::byte_t p2;
  wire trs_pkg::byte_t reply_byte;
  wire logic           reply_valid;

  // spi pins to bytes and back
  spi_link u_spi_link (
    .clk           (clk),
    .rst_n         (rst_n),
    .sck           (sck),
    .mosi          (mosi),
    .cs_n          (cs_n),
    .miso          (miso),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .msg_start     (msg_start),
    .reply_byte    (reply_byte),
    .reply_valid   (reply_valid),
    .reply_pending ()
  );

  // bytes to command + params
  cmd_parser u_cmd_parser (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .msg_start (msg_start),
    .action    (action),
    .cmd       (cmd),
    .p0        (p0),
    .p1        (p1),
    .p2        (p2)
  );

  // memory, colour and replies
  cmd_exec u_cmd_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .action       (action),
    .cmd          (cmd),
    .p0           (p0),
    .p1           (p1),
    .p2           (p2),
    .reply_byte   (reply_byte),
    .reply_valid  (reply_valid),
    .screen_color (screen_color)
  );

endmodule

`default_nettype wire

//--- logic/trs_pkg.sv
`default_nettype none

package trs_pkg;

  typedef logic [7:0]  byte_t;   // rx byte, parameter or reply
  typedef logic [23:0] color_t;  // {red, green, blue}

  localparam int MEM_ADDR_W = 10;  // upper address bits ignored, addresses alias
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // command codes seen on the spi link
  typedef enum logic [7:0] {
    CMD_GET_COOKIE       = 8'd0,
    CMD_BRAM_POKE        = 8'd1,
    CMD_BRAM_PEEK        = 8'd2,
    CMD_GET_VERSION      = 8'd15,
    CMD_SET_SCREEN_COLOR = 8'd17
  } cmd_t;

  localparam int MAX_PARAMS = 3;   // parameter slots p0..p2
  typedef logic [1:0] param_cnt_t;

  localparam byte_t      COOKIE        = 8'haf;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;  // top 3 bits of version reply
  localparam logic [4:0] VERSION_MINOR = 5'd3;  // low 5 bits
  localparam color_t     COLOR_RESET   = 24'hffffff;  // white

  typedef enum logic {
    PARSE_IDLE,    // waiting for command byte
    PARSE_PARAMS   // collecting parameters
  } parse_state_t;

  // true for the command codes this chip acts on
  function automatic logic cmd_is_known(byte_t code);
    return code inside {CMD_GET_COOKIE, CMD_BRAM_POKE, CMD_BRAM_PEEK,
                        CMD_GET_VERSION, CMD_SET_SCREEN_COLOR};
  endfunction

  // parameter bytes following each command byte
  function automatic param_cnt_t cmd_param_cnt(byte_t code);
    case (code)
      CMD_BRAM_POKE:        return 2'd3;  // addr lo, addr hi, data
      CMD_SET_SCREEN_COLOR: return 2'd3;  // r, g, b
      CMD_BRAM_PEEK:        return 2'd2;  // addr lo, addr hi
      default:              return 2'd0;  // queries
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verif/tb_trs_cmd.sv
`default_nettype none

module tb_trs_cmd;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_SCK    = 8;   // clk cycles per sck half-period
  localparam int GAP         = 8;   // idle cycles between bytes and around cs_n edges
  localparam int ADDR_BITS   = trs_pkg::MEM_ADDR_W;
  localparam int NUM_TESTS   = 18;
  localparam int BYTE_CYCLES = 16 * HALF_SCK + GAP;
  // abort is the longest entry with two messages and six bytes
  localparam int TXN_CYCLES      = 6 * BYTE_CYCLES + 4 * (GAP + 1);
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TXN_CYCLES * 2;

  typedef enum logic [2:0] {
    OP_POKE,
    OP_PEEK,
    OP_COOKIE,
    OP_VERSION,
    OP_COLOR,
    OP_ABORT,   // poke cut short by cs_n, then peek
    OP_UNKNOWN  // bad code then cookie, same message
  } op_t;

  typedef struct {
    op_t         op;
    logic [15:0] addr;  // {hi, lo} as sent
    logic [23:0] data;  // poke byte in [7:0], colour uses all
    logic [23:0] exp;   // expected reply byte or colour
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  logic                 sck;
  logic                 mosi;
  logic                 cs_n;
  wire logic            miso;
  wire trs_pkg::color_t screen_color;

  entry_t      tests [NUM_TESTS];
  logic [7:0]  ref_mem [1 << ADDR_BITS];  // memory model, low address bits only
  logic [23:0] color_model;
  integer      seed = 7194;
  int          n_tests;
  int          pass_count;
  int          fail_count;

  trs_cmd_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .mosi         (mosi),
    .cs_n         (cs_n),
    .miso         (miso),
    .screen_color (screen_color)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  function automatic string op_name(input op_t op);
    case (op)
      OP_POKE:    return "poke";
      OP_PEEK:    return "peek";
      OP_COOKIE:  return "cookie";
      OP_VERSION: return "version";
      OP_COLOR:   return "colour";
      OP_ABORT:   return "abort";
      default:    return "unknown";
    endcase
  endfunction

  task automatic wait_clk(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic msg_begin();
    @(negedge clk);
    cs_n = 1'b0;
    wait_clk(GAP);  // cs_n to first sck edge
  endtask

  task automatic msg_end();
    cs_n = 1'b1;  // byte gap already elapsed
    wait_clk(GAP);
  endtask

  // one spi mode 0 byte, msb first
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_clk(HALF_SCK);
      rx[i] = miso;  // sampled as sck rises
      sck   = 1'b1;
      wait_clk(HALF_SCK);
      sck = 1'b0;
    end
    wait_clk(GAP);
  endtask

  task automatic add_test(input op_t op, input logic [15:0] addr,
                          input logic [23:0] data, input logic [23:0] exp);
    tests[n_tests].op   = op;
    tests[n_tests].addr = addr;
    tests[n_tests].data = data;
    tests[n_tests].exp  = exp;
    n_tests++;
  endtask

  // table built up front, model tracks pokes in order
  task automatic build_tests();
    int          r;
    int          i;
    logic [15:0] a [4];
    logic [7:0]  d;
    logic [7:0]  d2;
    add_test(OP_COOKIE, 16'h0, 24'h0, 24'h0000af);
    add_test(OP_VERSION, 16'h0, 24'h0, 24'h000003);  // 0.3 -> {3'd0, 5'd3}
    for (i = 0; i < 4; i++) begin
      r    = $random(seed);
      a[i] = r[15:0];  // full 16 bits, upper ones ignored by dut
      d    = r[23:16];
      ref_mem[a[i][ADDR_BITS-1:0]] = d;
      add_test(OP_POKE, a[i], {16'h0, d}, 24'h0);
    end
    for (i = 0; i < 4; i++)
      add_test(OP_PEEK, a[i], 24'h0, {16'h0, ref_mem[a[i][ADDR_BITS-1:0]]});
    // alias pair, differs only in bit 10
    r  = $random(seed);
    d  = r[7:0];
    d2 = d ^ 8'h5a;  // later poke always differs
    ref_mem[10'h123] = d;
    add_test(OP_POKE, 16'h0123, {16'h0, d}, 24'h0);
    ref_mem[10'h123] = d2;
    add_test(OP_POKE, 16'h0523, {16'h0, d2}, 24'h0);
    add_test(OP_PEEK, 16'h0123, 24'h0, {16'h0, d2});
    r = $random(seed);
    color_model = r[23:0];
    add_test(OP_COLOR, 16'h0, r[23:0], r[23:0]);
    add_test(OP_ABORT, a[0], 24'h0, {16'h0, ref_mem[a[0][ADDR_BITS-1:0]]});
    add_test(OP_UNKNOWN, 16'h0, 24'h0, 24'h0000af);
    add_test(OP_VERSION, 16'h0, 24'h0, 24'h000003);
    add_test(OP_COOKIE, 16'h0, 24'h0, 24'h0000af);
  endtask

  task automatic report_test(input int idx, input string name, input logic ok);
    if (ok) begin
      pass_count++;
      $display("test %0d %s: pass", idx, name);
    end else begin
      fail_count++;
      $display("test %0d %s: fail", idx, name);
    end
  endtask

  task automatic apply_test(input int idx);
    entry_t      t;
    logic [7:0]  rx;
    logic [23:0] got;
    logic        ok;
    t   = tests[idx];
    got = '0;
    ok  = 1'b1;
    case (t.op)
      OP_POKE: begin
        msg_begin();
        spi_byte(8'h01, rx);
        spi_byte(t.addr[7:0], rx);
        spi_byte(t.addr[15:8], rx);
        spi_byte(t.data[7:0], rx);
        msg_end();
      end
      OP_PEEK: begin
        msg_begin();
        spi_byte(8'h02, rx);
        spi_byte(t.addr[7:0], rx);
        spi_byte(t.addr[15:8], rx);
        spi_byte(8'hff, rx);  // dummy clocks the reply out
        got = {16'h0, rx};
        msg_end();
      end
      OP_COOKIE, OP_VERSION: begin
        msg_begin();
        spi_byte((t.op == OP_COOKIE) ? 8'h00 : 8'h0f, rx);
        spi_byte(8'hff, rx);
        got = {16'h0, rx};
        msg_end();
      end
      OP_COLOR: begin
        msg_begin();
        spi_byte(8'h11, rx);
        spi_byte(t.data[23:16], rx);  // red first
        spi_byte(t.data[15:8], rx);
        spi_byte(t.data[7:0], rx);
        msg_end();
        got = screen_color;
      end
      OP_ABORT: begin
        msg_begin();
        spi_byte(8'h01, rx);
        spi_byte(t.addr[7:0], rx);
        msg_end();  // poke dropped here
        msg_begin();
        spi_byte(8'h02, rx);
        spi_byte(t.addr[7:0], rx);
        spi_byte(t.addr[15:8], rx);
        spi_byte(8'hff, rx);
        got = {16'h0, rx};
        msg_end();
      end
      default: begin
        msg_begin();
        spi_byte(8'h3c, rx);  // not a command
        spi_byte(8'h00, rx);
        spi_byte(8'hff, rx);
        got = {16'h0, rx};
        msg_end();
      end
    endcase
    if (t.op == OP_COLOR && got !== t.exp) begin
      $display("CHECK FAILED test %0d screen_color expected %h got %h", idx, t.exp, got);
      ok = 1'b0;
    end
    if (t.op != OP_POKE && t.op != OP_COLOR && got[7:0] !== t.exp[7:0]) begin
      $display("CHECK FAILED test %0d miso expected %h got %h", idx, t.exp[7:0], got[7:0]);
      ok = 1'b0;
    end
    report_test(idx, op_name(t.op), ok);
  endtask

  initial begin
    logic ok;
    int   i;
    rst_n      = 1'b0;
    sck        = 1'b0;
    mosi       = 1'b0;
    cs_n       = 1'b1;
    n_tests    = 0;
    pass_count = 0;
    fail_count = 0;
    build_tests();
    if (n_tests != NUM_TESTS) begin
      $display("test table holds %0d entries instead of %0d", n_tests, NUM_TESTS);
      fail_count++;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    wait_clk(GAP);
    // state straight out of reset
    ok = 1'b1;
    if (screen_color !== 24'hffffff) begin
      $display("CHECK FAILED reset screen_color expected ffffff got %h", screen_color);
      ok = 1'b0;
    end
    if (miso !== 1'b0) begin
      $display("CHECK FAILED reset miso expected 0 got %h", miso);
      ok = 1'b0;
    end
    report_test(-1, "reset", ok);
    for (i = 0; i < NUM_TESTS; i++)
      apply_test(i);
    // colour must survive the later commands
    ok = 1'b1;
    if (screen_color !== color_model) begin
      $display("CHECK FAILED hold screen_color expected %h got %h", color_model, screen_color);
      ok = 1'b0;
    end
    report_test(NUM_TESTS, "colour hold", ok);
    $display("%0d tests run, %0d passed, %0d failed",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/trs_pkg.sv
logic/spi_link.sv
logic/cmd_parser.sv
logic/cmd_exec.sv
logic/trs_cmd_top.sv
verif/tb_trs_cmd.sv
